/* src/ahb_pkg.sv */
////////////////////////////////////////////////////////////
// AHB-Lite bus encodings, widths, slave state and the
// packed address-phase bundle
////////////////////////////////////////////////////////////
package ahb_pkg;

   // Bus widths
   localparam int AHB_AW = 32;
   localparam int AHB_DW = 32;

   // HTRANS codes
   typedef enum logic [1:0] {
      TRN_IDLE   = 2'b00,
      TRN_BUSY   = 2'b01,
      TRN_NONSEQ = 2'b10,
      TRN_SEQ    = 2'b11
   } htrans_e;

   // Only SINGLE, INCR, WRAP4 and INCR4 of the HBURST codes are served
   typedef enum logic [2:0] {
      BURST_SINGLE = 3'b000,
      BURST_INCR   = 3'b001,
      BURST_WRAP4  = 3'b010,
      BURST_INCR4  = 3'b011,
      BURST_WRAP8  = 3'b100,
      BURST_INCR8  = 3'b101,
      BURST_WRAP16 = 3'b110,
      BURST_INCR16 = 3'b111
   } hburst_e;

   // HSIZE codes up to one word
   typedef enum logic [2:0] {
      SIZE_BYTE = 3'b000,
      SIZE_HALF = 3'b001,
      SIZE_WORD = 3'b010
   } hsize_e;

   typedef enum logic {
      RESP_OKAY  = 1'b0,
      RESP_ERROR = 1'b1
   } hresp_e;

   // Kind of data phase in flight
   typedef enum logic [1:0] {
      ST_IDLE = 2'b00,
      ST_WR   = 2'b01,
      ST_RD   = 2'b10
   } ahb_state_e;

   // Address-phase fields as seen by the slave
   typedef struct packed {
      logic [AHB_AW-1:0] addr;
      htrans_e           trans;
      hburst_e           burst;
      hsize_e            size;
      logic              write;
      logic              sel;
      logic              ready_in;
   } ahb_ctrl_t;

endpackage

/* src/sram_pkg.sv */
////////////////////////////////////////////////////////////
// SRAM geometry and the memory request bundle
////////////////////////////////////////////////////////////
package sram_pkg;
   import ahb_pkg::*;

   // 512 words of 32 bits make 2 KB of byte space
   localparam int MEM_DEPTH = 512;
   localparam int MEM_AW    = 9;
   localparam int BYTE_AW   = 11;
   localparam int LANES     = 4;

   // One access to the array per clock
   typedef struct packed {
      logic               wen;
      logic               ren;
      logic [BYTE_AW-1:0] addr;
      hsize_e             size;
      logic [AHB_DW-1:0]  wdata;
   } mem_req_t;

endpackage

/* src/ahb_cmd_ctrl.sv */
////////////////////////////////////////////////////////////
// Transfer decode, slave FSM, HREADYOUT wait-state control
// and the write data-phase register
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ahb_cmd_ctrl
   import ahb_pkg::*, sram_pkg::*;
(
   input  logic              HCLK,
   input  logic              aresetn,
   input  ahb_ctrl_t         bus,
   input  logic [AHB_DW-1:0] hwdata,
   output logic              hreadyout,
   output mem_req_t          wr_req,
   output logic              new_read
);

   logic               valid;
   logic               nonseq_rd;
   ahb_state_e         state;
   ahb_state_e         state_nxt;
   logic [BYTE_AW-1:0] wr_addr;
   hsize_e             wr_size;

   ////////////////////////////////////////////////////////////
   // Address-phase decode
   ////////////////////////////////////////////////////////////

   // Accepted NONSEQ or SEQ transfer
   assign valid = bus.sel & bus.ready_in & hreadyout &
                  ((bus.trans == TRN_NONSEQ) | (bus.trans == TRN_SEQ));

   // First beat of a read costs one wait state
   assign nonseq_rd = valid & ~bus.write & (bus.trans == TRN_NONSEQ);

   ////////////////////////////////////////////////////////////
   // Slave FSM
   ////////////////////////////////////////////////////////////

   // Next data phase follows the accepted address phase
   always_comb begin
      state_nxt = state;
      if (valid) begin
         if (bus.write) begin
            state_nxt = ST_WR;
         end else begin
            state_nxt = ST_RD;
         end
      end else if (hreadyout & bus.ready_in) begin
         // Data phase done with nothing new behind it
         state_nxt = ST_IDLE;
      end
   end

   always_ff @(posedge HCLK or negedge aresetn) begin
      if (!aresetn) begin
         state <= ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // One-cycle pulse in the wait cycle of a new read
   always_ff @(posedge HCLK or negedge aresetn) begin
      if (!aresetn) begin
         new_read <= 1'b0;
      end else begin
         new_read <= nonseq_rd;
      end
   end

   // Array read latency is covered by this single wait state
   assign hreadyout = ~new_read;

   ////////////////////////////////////////////////////////////
   // Write data-phase register
   ////////////////////////////////////////////////////////////

   // Address and size held for the data phase
   always_ff @(posedge HCLK) begin
      if (valid & bus.write) begin
         wr_addr <= bus.addr[BYTE_AW-1:0];
         wr_size <= bus.size;
      end
   end

   // Write lands at the end of the data phase with live HWDATA
   always_comb begin
      wr_req.wen   = (state == ST_WR);
      // Later beats read on the fly once the wait cycle is over
      wr_req.ren   = (state == ST_RD) & hreadyout;
      wr_req.addr  = wr_addr;
      wr_req.size  = wr_size;
      wr_req.wdata = hwdata;
   end

endmodule

/* src/burst_addr_gen.sv */
////////////////////////////////////////////////////////////
// Read address generator running ahead of the bus,
// incrementing and wrapping bursts
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module burst_addr_gen
   import ahb_pkg::*, sram_pkg::*;
(
   input  logic               HCLK,
   input  logic               aresetn,
   input  ahb_ctrl_t          bus,
   input  logic               hreadyout,
   output logic [BYTE_AW-1:0] rd_addr
);

   logic               accept;
   logic               load;
   logic               step_en;
   logic [BYTE_AW-1:0] size_step;
   logic [BYTE_AW-1:0] size_mask;
   logic [BYTE_AW-1:0] addr_q;
   logic [BYTE_AW-1:0] addr_nxt;
   logic [BYTE_AW-1:0] step_q;
   logic [BYTE_AW-1:0] mask_q;
   logic               wrap_q;

   // Accepted read transfer
   assign accept  = bus.sel & bus.ready_in & hreadyout & ~bus.write;
   assign load    = accept & (bus.trans == TRN_NONSEQ);
   assign step_en = accept & (bus.trans == TRN_SEQ);

   // Step and 4-beat window mask per size
   // mask covers the beat-select bits inside the window
   always_comb begin
      case (bus.size)
         SIZE_BYTE: begin
            size_step = BYTE_AW'(1);
            size_mask = BYTE_AW'(3);
         end
         SIZE_HALF: begin
            size_step = BYTE_AW'(2);
            size_mask = BYTE_AW'(6);
         end
         default: begin
            size_step = BYTE_AW'(4);
            size_mask = BYTE_AW'(12);
         end
      endcase
   end

   // Top of a WRAP4 window folds back to its base
   always_comb begin
      if (wrap_q && ((addr_q & mask_q) == mask_q)) begin
         addr_nxt = addr_q & ~mask_q;
      end else begin
         addr_nxt = addr_q + step_q;
      end
   end

   always_ff @(posedge HCLK or negedge aresetn) begin
      if (!aresetn) begin
         addr_q <= '0;
         step_q <= '0;
         mask_q <= '0;
         wrap_q <= 1'b0;
      end else if (load) begin
         addr_q <= bus.addr[BYTE_AW-1:0];
         step_q <= size_step;
         mask_q <= size_mask;
         wrap_q <= (bus.burst == BURST_WRAP4);
      end else if (step_en) begin
         addr_q <= addr_nxt;
      end
   end

   // Next beat address goes out in the SEQ address phase itself,
   // so the array has it in time for a zero-wait data phase
   assign rd_addr = step_en ? addr_nxt : addr_q;

endmodule

/* src/sram_array.sv */
////////////////////////////////////////////////////////////
// Byte-lane write decode and word SRAM, registered read
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sram_array
   import ahb_pkg::*, sram_pkg::*;
(
   input  logic              HCLK,
   input  mem_req_t          req,
   output logic [AHB_DW-1:0] rdata
);

   logic [LANES-1:0]      lane_en;
   logic [MEM_AW-1:0]     word_idx;
   logic [LANES-1:0][7:0] mem [MEM_DEPTH];

   // Byte address to word index wrapping at MEM_DEPTH
   assign word_idx = req.addr[BYTE_AW-1:2];

   ////////////////////////////////////////////////////////////
   // Lane enables from size and low address bits
   ////////////////////////////////////////////////////////////

   always_comb begin
      case (req.size)
         SIZE_BYTE: begin
            lane_en = {{(LANES-1){1'b0}}, 1'b1} << req.addr[1:0];
         end
         SIZE_HALF: begin
            // Bit 1 picks the upper or lower half
            if (req.addr[1]) begin
               lane_en = 4'b1100;
            end else begin
               lane_en = 4'b0011;
            end
         end
         default: begin
            lane_en = {LANES{1'b1}};
         end
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Storage
   ////////////////////////////////////////////////////////////

   always_ff @(posedge HCLK) begin
      if (req.wen) begin
         for (int i = 0; i < LANES; i++) begin
            if (lane_en[i]) begin
               mem[word_idx][i] <= req.wdata[8*i +: 8];
            end
         end
      end
      // One edge read latency
      if (req.ren) begin
         rdata <= mem[word_idx];
      end
   end

endmodule

/* src/ahb_lsram.sv */
////////////////////////////////////////////////////////////
// AHB-Lite SRAM slave top, bus packing, request merge
// and read-data return
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ahb_lsram
   import ahb_pkg::*, sram_pkg::*;
(
   input  logic              HCLK,
   input  logic              aresetn,
   input  logic              HSEL,
   input  htrans_e           HTRANS,
   input  hburst_e           HBURST,
   input  hsize_e            HSIZE,
   input  logic              HWRITE,
   input  logic [AHB_AW-1:0] HADDR,
   input  logic [AHB_DW-1:0] HWDATA,
   input  logic              HREADY,
   output logic              HREADYOUT,
   output hresp_e            HRESP,
   output logic [AHB_DW-1:0] HRDATA
);

   ahb_ctrl_t          bus;
   mem_req_t           wr_req;
   mem_req_t           mem_req;
   logic               new_read;
   logic [BYTE_AW-1:0] rd_addr;

   // Address-phase bundle
   assign bus = '{addr: HADDR, trans: HTRANS, burst: HBURST, size: HSIZE,
                  write: HWRITE, sel: HSEL, ready_in: HREADY};

   ahb_cmd_ctrl u_cmd_ctrl (
      .HCLK      (HCLK),
      .aresetn   (aresetn),
      .bus       (bus),
      .hwdata    (HWDATA),
      .hreadyout (HREADYOUT),
      .wr_req    (wr_req),
      .new_read  (new_read)
   );

   burst_addr_gen u_addr_gen (
      .HCLK      (HCLK),
      .aresetn   (aresetn),
      .bus       (bus),
      .hreadyout (HREADYOUT),
      .rd_addr   (rd_addr)
   );

   // Pending write owns the address and reads use the generator
   // First-beat read in the wait cycle and streaming reads after that
   always_comb begin
      mem_req      = wr_req;
      mem_req.ren  = wr_req.ren | new_read;
      mem_req.addr = wr_req.wen ? wr_req.addr : rd_addr;
   end

   sram_array u_array (
      .HCLK  (HCLK),
      .req   (mem_req),
      .rdata (HRDATA)
   );

   // No error responses
   assign HRESP = RESP_OKAY;

endmodule

/* bench/ahb_lsram_props.sv */
////////////////////////////////////////////////////////////
// Concurrent checks on HRESP, HREADYOUT and the array write
// enable, bound into the SRAM slave top
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ahb_lsram_props
   import ahb_pkg::*;
(
   input logic       HCLK,
   input logic       aresetn,
   input logic       HSEL,
   input htrans_e    HTRANS,
   input logic       HWRITE,
   input logic       HREADY,
   input logic       HREADYOUT,
   input hresp_e     HRESP,
   input logic       mem_wen,
   input ahb_state_e state
);

   logic wr_accept;

   // Write accepted in the address phase
   assign wr_accept = HSEL & HREADY & HREADYOUT & HWRITE &
                      ((HTRANS == TRN_NONSEQ) | (HTRANS == TRN_SEQ));

   // Slave never signals an error
   property p_resp_okay;
      @(posedge HCLK) disable iff (!aresetn)
         HRESP == RESP_OKAY;
   endproperty

   // At most one wait state per transfer
   property p_single_wait;
      @(posedge HCLK) disable iff (!aresetn)
         !HREADYOUT |=> HREADYOUT;
   endproperty

   // Ready straight out of reset
   property p_ready_after_reset;
      @(posedge HCLK) $rose(aresetn) |-> HREADYOUT;
   endproperty

   // Array writes only in the WR data phase of an accepted write
   property p_wen_in_wr;
      @(posedge HCLK) disable iff (!aresetn)
         mem_wen |-> (state == ST_WR) && $past(wr_accept);
   endproperty

   a_resp_okay: assert property (p_resp_okay)
      else $error("HRESP is not OKAY");

   a_single_wait: assert property (p_single_wait)
      else $error("HREADYOUT low for two cycles in a row");

   a_ready_after_reset: assert property (p_ready_after_reset)
      else $error("HREADYOUT low in the first cycle after reset");

   a_wen_in_wr: assert property (p_wen_in_wr)
      else $error("Array write enable outside the data phase of an accepted write");

endmodule

bind ahb_lsram ahb_lsram_props u_props (
   .HCLK      (HCLK),
   .aresetn   (aresetn),
   .HSEL      (HSEL),
   .HTRANS    (HTRANS),
   .HWRITE    (HWRITE),
   .HREADY    (HREADY),
   .HREADYOUT (HREADYOUT),
   .HRESP     (HRESP),
   .mem_wen   (mem_req.wen),
   .state     (u_cmd_ctrl.state)
);

/* bench/tb_ahb_lsram.sv */
////////////////////////////////////////////////////////////
// Testbench for the AHB-Lite SRAM slave, pipelined master,
// byte-lane reference memory and directed tests
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_ahb_lsram
   import ahb_pkg::*;
();

   localparam int CLK_NS       = 8;
   localparam int RESET_CYCLES = 4;
   // Beats per test in the order the tests run
   localparam int TOTAL_BEATS  = 16 + 8 + 8 + 8 + 8 + 8;
   localparam int WATCHDOG_NS  = 2 * (TOTAL_BEATS * 4 * CLK_NS) + RESET_CYCLES * CLK_NS;

   // One bus transfer as queued for the master
   typedef struct packed {
      logic [31:0] addr;
      logic [31:0] wdata;
      htrans_e     trans;
      hburst_e     burst;
      hsize_e      size;
      logic        write;
   } xfer_t;

   logic        HCLK;
   logic        aresetn;
   logic        HSEL;
   htrans_e     HTRANS;
   hburst_e     HBURST;
   hsize_e      HSIZE;
   logic        HWRITE;
   logic [31:0] HADDR;
   logic [31:0] HWDATA;
   logic        HREADY;
   logic        HREADYOUT;
   hresp_e      HRESP;
   logic [31:0] HRDATA;

   logic [7:0]  ref_mem [2048];
   xfer_t       xq [$];
   logic [16:0] lfsr_q = 17'd93553;
   int          errors = 0;
   int          checks = 0;
   int          tests  = 0;

   // HREADY follows the only slave on the bus
   assign HREADY = HREADYOUT;

   ahb_lsram UUT (
      .HCLK (HCLK), .aresetn (aresetn), .HSEL (HSEL), .HTRANS (HTRANS),
      .HBURST (HBURST), .HSIZE (HSIZE), .HWRITE (HWRITE), .HADDR (HADDR),
      .HWDATA (HWDATA), .HREADY (HREADY), .HREADYOUT (HREADYOUT),
      .HRESP (HRESP), .HRDATA (HRDATA)
   );

   initial begin
      HCLK = 1'b0;
      forever #(CLK_NS / 2) HCLK = ~HCLK;
   end

   ////////////////////////////////////////////////////////////
   // Random source and reference model
   ////////////////////////////////////////////////////////////

   // Maximal-length taps at bits 17 and 14
   function automatic logic [16:0] lfsr_next(input logic [16:0] s);
      return {s[15:0], s[16] ^ s[13]};
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         v = {v[30:0], lfsr_q[0]};
      end
   endtask

   // Bytes pick a lane by addr[1:0], halves by addr[1] and words use all four
   task automatic model_write(input xfer_t x);
      int lo;
      int cnt;
      int base;
      base = x.addr[10:0] & 11'h7fc;
      case (x.size)
         SIZE_BYTE: begin
            lo  = x.addr[1:0];
            cnt = 1;
         end
         SIZE_HALF: begin
            lo  = x.addr[1] ? 2 : 0;
            cnt = 2;
         end
         default: begin
            lo  = 0;
            cnt = 4;
         end
      endcase
      for (int i = lo; i < lo + cnt; i++) begin
         ref_mem[base + i] = x.wdata[8*i +: 8];
      end
   endtask

   function automatic logic [31:0] model_word(input logic [31:0] addr);
      int base;
      base = addr[10:0] & 11'h7fc;
      return {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
   endfunction

   // Word-size WRAP4 beat inside the aligned 16-byte block
   function automatic logic [31:0] wrap4_addr(input logic [31:0] start, input int beat);
      return (start & ~32'hc) | ((start + 4 * beat) & 32'hc);
   endfunction

   ////////////////////////////////////////////////////////////
   // Bus master
   ////////////////////////////////////////////////////////////

   task automatic push_xfer(input logic [31:0] addr, input logic write, input hsize_e size,
                            input hburst_e burst, input htrans_e trans, input logic [31:0] wdata);
      xq.push_back('{addr: addr, wdata: wdata, trans: trans, burst: burst,
                     size: size, write: write});
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("[ERROR] %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   // Wait states, response and data once the data phase is done
   task automatic finish_beat(input xfer_t x, input int waits);
      int exp_waits;
      exp_waits = (!x.write && x.trans == TRN_NONSEQ) ? 1 : 0;
      checks++;
      assert (waits == exp_waits) else begin
         $display("Transfer at address %h took %0d wait cycles instead of %0d",
                  x.addr, waits, exp_waits);
         errors++;
      end
      check_value("HRESP", 32'(HRESP), 32'(RESP_OKAY));
      if (x.write) begin
         model_write(x);
      end else begin
         check_value("HRDATA", HRDATA, model_word(x.addr));
      end
   endtask

   // Address phase of beat i overlaps the data phase of beat i-1
   task automatic run_xfers();
      xfer_t cur;
      xfer_t prev;
      int    waits;
      int    n;
      n = xq.size();
      for (int i = 0; i <= n; i++) begin
         @(posedge HCLK);
         if (i < n) begin
            cur = xq[i];
            HSEL   <= 1'b1;
            HTRANS <= cur.trans;
            HBURST <= cur.burst;
            HSIZE  <= cur.size;
            HWRITE <= cur.write;
            HADDR  <= cur.addr;
         end else begin
            HSEL   <= 1'b0;
            HTRANS <= TRN_IDLE;
            HWRITE <= 1'b0;
         end
         if (i > 0) begin
            if (prev.write) begin
               HWDATA <= prev.wdata;
            end
         end
         // Sampled mid-cycle while the address phase is held through waits
         waits = 0;
         @(negedge HCLK);
         while (!HREADYOUT) begin
            waits++;
            @(negedge HCLK);
         end
         if (i > 0) begin
            finish_beat(prev, waits);
         end
         prev = cur;
      end
      xq.delete();
   endtask

   task automatic report_test(input string name, input int err_before);
      tests++;
      $display("%-24s %s", name, (errors == err_before) ? "ok" : "FAILED");
   endtask

   ////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////

   task automatic test_word_rw();
      logic [31:0] addr [8];
      logic [31:0] d;
      int          err0;
      err0 = errors;
      for (int i = 0; i < 8; i++) begin
         rand_bits(9, d);
         addr[i] = d << 2;
         rand_bits(32, d);
         push_xfer(addr[i], 1'b1, SIZE_WORD, BURST_SINGLE, TRN_NONSEQ, d);
      end
      for (int i = 0; i < 8; i++) begin
         push_xfer(addr[i], 1'b0, SIZE_WORD, BURST_SINGLE, TRN_NONSEQ, '0);
      end
      run_xfers();
      report_test("word write and read", err0);
   endtask

   task automatic test_byte_half();
      logic [31:0] base;
      logic [31:0] off;
      logic [31:0] d;
      int          err0;
      err0 = errors;
      for (int r = 0; r < 2; r++) begin
         rand_bits(9, base);
         base = base << 2;
         rand_bits(32, d);
         push_xfer(base, 1'b1, SIZE_WORD, BURST_SINGLE, TRN_NONSEQ, d);
         rand_bits(2, off);
         rand_bits(32, d);
         push_xfer(base + off, 1'b1, SIZE_BYTE, BURST_SINGLE, TRN_NONSEQ, d);
         rand_bits(1, off);
         rand_bits(32, d);
         push_xfer(base + 2 * off, 1'b1, SIZE_HALF, BURST_SINGLE, TRN_NONSEQ, d);
         push_xfer(base, 1'b0, SIZE_WORD, BURST_SINGLE, TRN_NONSEQ, '0);
      end
      run_xfers();
      report_test("byte and halfword lanes", err0);
   endtask

   task automatic test_incr4_read();
      logic [31:0] base;
      logic [31:0] d;
      int          err0;
      err0 = errors;
      rand_bits(7, base);
      base = base << 4;
      for (int i = 0; i < 4; i++) begin
         rand_bits(32, d);
         push_xfer(base + 4 * i, 1'b1, SIZE_WORD, BURST_SINGLE, TRN_NONSEQ, d);
      end
      for (int i = 0; i < 4; i++) begin
         push_xfer(base + 4 * i, 1'b0, SIZE_WORD, BURST_INCR4,
                   (i == 0) ? TRN_NONSEQ : TRN_SEQ, '0);
      end
      run_xfers();
      report_test("INCR4 read burst", err0);
   endtask

   task automatic test_wrap4_read();
      logic [31:0] base;
      logic [31:0] d;
      int          err0;
      err0 = errors;
      rand_bits(7, base);
      base = base << 4;
      for (int i = 0; i < 4; i++) begin
         rand_bits(32, d);
         push_xfer(base + 4 * i, 1'b1, SIZE_WORD, BURST_SINGLE, TRN_NONSEQ, d);
      end
      // Starting at word offset 2 the beats cover offsets 2, 3, 0 and 1
      for (int i = 0; i < 4; i++) begin
         push_xfer(wrap4_addr(base + 8, i), 1'b0, SIZE_WORD, BURST_WRAP4,
                   (i == 0) ? TRN_NONSEQ : TRN_SEQ, '0);
      end
      run_xfers();
      report_test("WRAP4 read burst", err0);
   endtask

   task automatic test_write_then_read();
      logic [31:0] addr;
      logic [31:0] d;
      int          err0;
      err0 = errors;
      for (int i = 0; i < 4; i++) begin
         rand_bits(9, addr);
         addr = addr << 2;
         rand_bits(32, d);
         push_xfer(addr, 1'b1, SIZE_WORD, BURST_SINGLE, TRN_NONSEQ, d);
         push_xfer(addr, 1'b0, SIZE_WORD, BURST_SINGLE, TRN_NONSEQ, '0);
      end
      run_xfers();
      report_test("read right after write", err0);
   endtask

   task automatic test_incr4_write();
      logic [31:0] base;
      logic [31:0] d;
      int          err0;
      err0 = errors;
      rand_bits(7, base);
      base = base << 4;
      for (int i = 0; i < 4; i++) begin
         rand_bits(32, d);
         push_xfer(base + 4 * i, 1'b1, SIZE_WORD, BURST_INCR4,
                   (i == 0) ? TRN_NONSEQ : TRN_SEQ, d);
      end
      for (int i = 0; i < 4; i++) begin
         push_xfer(base + 4 * i, 1'b0, SIZE_WORD, BURST_SINGLE, TRN_NONSEQ, '0);
      end
      run_xfers();
      report_test("INCR4 write burst", err0);
   endtask

   ////////////////////////////////////////////////////////////
   // Sequence and watchdog
   ////////////////////////////////////////////////////////////

   initial begin
      aresetn = 1'b0;
      HSEL    = 1'b0;
      HTRANS  = TRN_IDLE;
      HBURST  = BURST_SINGLE;
      HSIZE   = SIZE_WORD;
      HWRITE  = 1'b0;
      HADDR   = '0;
      HWDATA  = '0;
      repeat (RESET_CYCLES) @(posedge HCLK);
      aresetn <= 1'b1;
      @(posedge HCLK);
      test_word_rw();
      test_byte_half();
      test_incr4_read();
      test_wrap4_read();
      test_write_then_read();
      test_incr4_write();
      $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout, the tests did not complete within %0d ns", WATCHDOG_NS);
      $display("sim failed");
      $finish;
   end

endmodule

/* compile.f */
src/ahb_pkg.sv
src/sram_pkg.sv
src/ahb_cmd_ctrl.sv
src/burst_addr_gen.sv
src/sram_array.sv
src/ahb_lsram.sv
bench/ahb_lsram_props.sv
bench/tb_ahb_lsram.sv
